//--- Bender.yml
package:
  name: bbox_iterator

sources:
  # RTL, package first
  - files:
      - hdl/raster_pkg.sv
      - hdl/col_walker.sv
      - hdl/row_walker.sv
      - hdl/iter_sequencer.sv
      - hdl/bbox_iterator.sv

  # Bound assertions and testbench
  - target: simulation
    files:
      - sim/bbox_iterator_assert.sv
      - sim/tb_bbox_iterator.sv

//--- hdl/bbox_iterator.sv
/*
 * Bounding-box sample iterator
 * Walks subsample positions across a triangle's box in raster order,
 * one candidate per cycle, holding upstream while the walk runs
 */

`timescale 1ns/10ps

module bbox_iterator
    import raster_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  tri_t       tri_in,
    input  color_t     color_in,
    input  box_t       box_in,
    input  logic       valid_in,
    input  subsample_t subsample,
    output logic       halt_l,
    output tri_t       tri_out,
    output color_t     color_out,
    output sample_t    sample,
    output logic       sample_valid
);

    // Sequencer to walkers
    logic load;
    logic advance;

    // Walker edge flags back to the sequencer
    logic col_wrap;
    logic last_row;

    // Current walk position
    coord_t sample_x;
    coord_t sample_y;

    iter_sequencer u_seq (
        .clk          (clk),
        .rst          (rst),
        .valid_in     (valid_in),
        .tri_in       (tri_in),
        .color_in     (color_in),
        .col_wrap     (col_wrap),
        .last_row     (last_row),
        .load         (load),
        .advance      (advance),
        .halt_l       (halt_l),
        .sample_valid (sample_valid),
        .tri_out      (tri_out),
        .color_out    (color_out)
    );

    col_walker u_col (
        .clk       (clk),
        .rst       (rst),
        .load      (load),
        .advance   (advance),
        .box_in    (box_in),
        .subsample (subsample),
        .x         (sample_x),
        .col_wrap  (col_wrap)
    );

    // Steps up once per finished row
    row_walker u_row (
        .clk       (clk),
        .rst       (rst),
        .load      (load),
        .col_wrap  (col_wrap),
        .box_in    (box_in),
        .subsample (subsample),
        .y         (sample_y),
        .last_row  (last_row)
    );

    assign sample = '{x: sample_x, y: sample_y};

endmodule

//--- hdl/col_walker.sv
/*
 * Column walker
 * Holds the x position of the walk, steps right by the MSAA pitch
 * and wraps back to the left edge of the box at the right edge
 */

`timescale 1ns/10ps

module col_walker
    import raster_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic       load,
    input  logic       advance,
    input  box_t       box_in,
    input  subsample_t subsample,
    output coord_t     x,
    output logic       col_wrap
);

    // Horizontal extent of the current box
    coord_t min_x;
    coord_t max_x;

    // Spacing between neighbouring samples
    coord_t step;

    assign step = msaa_step(subsample);

    // Right edge reached on an advancing cycle
    // Also tells the row walker to move up
    assign col_wrap = advance && (x >= max_x);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            min_x <= '0;
            max_x <= '0;
            x     <= '0;
        end else if (load) begin
            // New box starts at its left edge
            min_x <= box_in.min_x;
            max_x <= box_in.max_x;
            x     <= box_in.min_x;
        end else if (col_wrap) begin
            // Next row starts back on the left
            x <= min_x;
        end else if (advance) begin
            x <= x + step;
        end
    end

    // x never runs past max_x by more than a step, since the
    // compare above is checked every advancing cycle
    // An unaligned box puts the last column just past max_x

endmodule

//--- hdl/iter_sequencer.sv
/*
 * Iterator sequencer
 * WAIT/TEST state machine that accepts a triangle, holds its payload,
 * drives the walkers and produces halt and sample valid
 */

`timescale 1ns/10ps

module iter_sequencer
    import raster_pkg::*;
(
    input  logic   clk,
    input  logic   rst,
    input  logic   valid_in,
    input  tri_t   tri_in,
    input  color_t color_in,
    input  logic   col_wrap,
    input  logic   last_row,
    output logic   load,
    output logic   advance,
    output logic   halt_l,
    output logic   sample_valid,
    output tri_t   tri_out,
    output color_t color_out
);

    iter_state_t state;
    iter_state_t next_state;

    // Right edge of the top row, this is the final sample
    logic end_walk;

    assign end_walk = col_wrap && last_row;

    // Accept only while idle, halt_l is high in WAIT
    assign load = (state == WAIT) && valid_in;

    // Walkers step on every TEST cycle
    assign advance = (state == TEST);

    // Both flags come straight off the state flop
    assign sample_valid = (state == TEST);
    assign halt_l       = (state == WAIT);

    always_comb begin
        next_state = state;
        case (state)
            WAIT: begin
                // Item on the input is taken this cycle
                if (valid_in) begin
                    next_state = TEST;
                end
            end
            TEST: begin
                // Last sample goes out now, idle next cycle
                if (end_walk) begin
                    next_state = WAIT;
                end
            end
            default: begin
                next_state = WAIT;
            end
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= WAIT;
        end else begin
            state <= next_state;
        end
    end

    // Payload travels with every sample of the walk
    // Upstream may change its inputs under halt, so capture on load only
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            tri_out   <= '0;
            color_out <= '0;
        end else if (load) begin
            tri_out   <= tri_in;
            color_out <= color_in;
        end
    end

    // Back-to-back items
    // end_walk returns to WAIT with halt_l high, so the next item
    // is accepted one cycle after the last sample

endmodule

//--- hdl/raster_pkg.sv
/*
 * Raster package for the bounding-box sample iterator
 * Fixed-point sizes, payload structs and the MSAA step helper
 */

package raster_pkg;

    // Fixed-point format, integer bits above RADIX
    localparam int SIGFIG = 24;
    localparam int RADIX = 10;

    // Triangle and color shape
    localparam int VERTS = 3;
    localparam int AXIS = 3;
    localparam int COLORS = 3;

    // One-hot MSAA code, 1000 is one sample per pixel
    localparam int SUBSAMPLE_W = 4;
    // Code bit 3 lands on the unit bit, so 1000 steps a whole pixel
    localparam int STEP_SHIFT = RADIX - 3;

    // Signed fixed-point coordinate
    typedef logic signed [SIGFIG-1:0] coord_t;

    // One vertex, axis 0 is x, 1 is y, 2 is z
    typedef struct packed {
        coord_t [AXIS-1:0] axis;
    } vertex_t;

    typedef struct packed {
        vertex_t [VERTS-1:0] vert;
    } tri_t;

    // Unsigned fixed-point channels
    typedef struct packed {
        logic [COLORS-1:0][SIGFIG-1:0] ch;
    } color_t;

    // Screen-space bounds, inclusive on all sides
    typedef struct packed {
        coord_t min_x;
        coord_t min_y;
        coord_t max_x;
        coord_t max_y;
    } box_t;

    // Candidate sample location
    typedef struct packed {
        coord_t x;
        coord_t y;
    } sample_t;

    typedef logic [SUBSAMPLE_W-1:0] subsample_t;

    typedef enum logic {
        WAIT = 1'b0,
        TEST = 1'b1
    } iter_state_t;

    // Sample spacing for an MSAA code
    function automatic coord_t msaa_step(input subsample_t code);
        return coord_t'({{(SIGFIG-SUBSAMPLE_W){1'b0}}, code}) << STEP_SHIFT;
    endfunction

endpackage

//--- hdl/row_walker.sv
/*
 * Row walker
 * Holds the y position of the walk, moves up a row on each column wrap
 * and flags when the current row is the top one
 */

`timescale 1ns/10ps

module row_walker
    import raster_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic       load,
    input  logic       col_wrap,
    input  box_t       box_in,
    input  subsample_t subsample,
    output coord_t     y,
    output logic       last_row
);

    // Only the top bound is needed after the start row is set
    coord_t max_y;

    // Row pitch, same as the column pitch
    coord_t step;

    assign step = msaa_step(subsample);

    // Top row once y is at or past max_y
    assign last_row = (y >= max_y);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            max_y <= '0;
            y     <= '0;
        end else if (load) begin
            // Walk starts on the bottom row
            max_y <= box_in.max_y;
            y     <= box_in.min_y;
        end else if (col_wrap) begin
            y <= y + step;
        end
    end

    // On the final wrap y also steps past max_y
    // Harmless, sample_valid is already low by then

endmodule

//--- sim.f
hdl/raster_pkg.sv
hdl/col_walker.sv
hdl/row_walker.sv
hdl/iter_sequencer.sv
hdl/bbox_iterator.sv
sim/bbox_iterator_assert.sv
sim/tb_bbox_iterator.sv

//--- sim/bbox_iterator_assert.sv
/*
 * Bound checker for the bounding-box sample iterator
 * Captures each accepted item and checks walk order, bounds, halt and payload
 */

`timescale 1ns/10ps

module bbox_iterator_assert
    import raster_pkg::*;
(
    input logic       clk,
    input logic       rst,
    input logic       valid_in,
    input logic       halt_l,
    input logic       sample_valid,
    input subsample_t subsample,
    input box_t       box_in,
    input tri_t       tri_in,
    input color_t     color_in,
    input tri_t       tri_out,
    input color_t     color_out,
    input sample_t    sample
);

    // Upstream handshake completes
    logic   accept;
    // Top right sample of the captured box
    logic   last_sample;

    box_t   cap_box;
    tri_t   cap_tri;
    color_t cap_color;
    coord_t cap_step;

    // Failed checks, read by the testbench
    int     err_count = 0;

    assign accept      = valid_in && halt_l;
    assign last_sample = sample_valid && (sample.x >= cap_box.max_x)
                         && (sample.y >= cap_box.max_y);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cap_box   <= '0;
            cap_tri   <= '0;
            cap_color <= '0;
            cap_step  <= '0;
        end else if (accept) begin
            cap_box   <= box_in;
            cap_tri   <= tri_in;
            cap_color <= color_in;
            // One-hot code with bit 3 on the unit bit
            cap_step  <= coord_t'(subsample) << (RADIX - 3);
        end
    end

    // Idle outputs while reset is held
    a_reset: assert property (@(posedge clk)
        (rst && $past(rst)) |-> (halt_l && !sample_valid))
        else begin
            err_count++;
            $error("Fail %0t: outputs not idle during reset", $time);
        end

    // Walk starts at the lower left corner
    a_first: assert property (@(posedge clk) disable iff (rst)
        accept |=> (sample_valid && sample.x == cap_box.min_x && sample.y == cap_box.min_y))
        else begin
            err_count++;
            $error("Fail %0t: first sample is not (min_x, min_y)", $time);
        end

    // Step right inside a row, or wrap to the next row after the right edge
    a_order: assert property (@(posedge clk) disable iff (rst)
        sample_valid |=> (!sample_valid
            || ($past(sample.x) < cap_box.max_x && sample.x == $past(sample.x) + cap_step
                && sample.y == $past(sample.y))
            || ($past(sample.x) >= cap_box.max_x && sample.x == cap_box.min_x
                && sample.y == $past(sample.y) + cap_step)))
        else begin
            err_count++;
            $error("Fail %0t: sample out of raster order", $time);
        end

    a_bounds: assert property (@(posedge clk) disable iff (rst)
        sample_valid |-> (sample.x >= cap_box.min_x && sample.x <= cap_box.max_x
            && sample.y >= cap_box.min_y && sample.y <= cap_box.max_y))
        else begin
            err_count++;
            $error("Fail %0t: sample outside the box", $time);
        end

    a_halt: assert property (@(posedge clk) disable iff (rst)
        sample_valid |-> !halt_l)
        else begin
            err_count++;
            $error("Fail %0t: halt_l high during a walk", $time);
        end

    // Valid continues until the top right sample, then drops with halt released
    a_end: assert property (@(posedge clk) disable iff (rst)
        sample_valid |=> (sample_valid != $past(last_sample)) && (halt_l == $past(last_sample)))
        else begin
            err_count++;
            $error("Fail %0t: walk ended at the wrong sample", $time);
        end

    a_payload: assert property (@(posedge clk) disable iff (rst)
        sample_valid |-> (tri_out == cap_tri && color_out == cap_color))
        else begin
            err_count++;
            $error("Fail %0t: payload differs from the accepted item", $time);
        end

endmodule

bind bbox_iterator bbox_iterator_assert u_chk (
    .clk          (clk),
    .rst          (rst),
    .valid_in     (valid_in),
    .halt_l       (halt_l),
    .sample_valid (sample_valid),
    .subsample    (subsample),
    .box_in       (box_in),
    .tri_in       (tri_in),
    .color_in     (color_in),
    .tri_out      (tri_out),
    .color_out    (color_out),
    .sample       (sample)
);

//--- sim/tb_bbox_iterator.sv
/*
 * Testbench for the bounding-box sample iterator
 * Random aligned boxes under every MSAA code, some walks back-to-back
 */

`timescale 1ns/10ps

module tb_bbox_iterator
    import raster_pkg::*;
();

    logic       clk;
    logic       rst;
    tri_t       tri_in;
    color_t     color_in;
    box_t       box_in;
    logic       valid_in;
    subsample_t subsample;
    logic       halt_l;
    tri_t       tri_out;
    color_t     color_out;
    sample_t    sample;
    logic       sample_valid;

    // Items built before reset, one per test
    subsample_t item_code[$];
    bit         item_chain[$];
    box_t       item_box[$];
    tri_t       item_tri[$];
    color_t     item_color[$];
    int         item_len[$];

    int cycle_limit = 0;
    int cycles = 0;
    int pass_count = 0;
    int fail_count = 0;

    bbox_iterator u_dut (
        .clk          (clk),
        .rst          (rst),
        .tri_in       (tri_in),
        .color_in     (color_in),
        .box_in       (box_in),
        .valid_in     (valid_in),
        .subsample    (subsample),
        .halt_l       (halt_l),
        .tri_out      (tri_out),
        .color_out    (color_out),
        .sample       (sample),
        .sample_valid (sample_valid)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    function automatic tri_t rand_tri();
        tri_t t;
        for (int v = 0; v < VERTS; v++) begin
            for (int a = 0; a < AXIS; a++) begin
                t.vert[v].axis[a] = coord_t'($urandom);
            end
        end
        return t;
    endfunction

    function automatic color_t rand_color();
        color_t c;
        for (int k = 0; k < COLORS; k++) begin
            c.ch[k] = SIGFIG'($urandom);
        end
        return c;
    endfunction

    // Product rule for an aligned box
    function automatic int walk_length(input box_t b, input int step);
        return ((int'(b.max_x) - int'(b.min_x)) / step + 1)
             * ((int'(b.max_y) - int'(b.min_y)) / step + 1);
    endfunction

    // Box on the step grid near the origin, up to 7 by 5 samples
    task automatic add_test(input subsample_t code, input bit chain, input bit single);
        box_t b;
        int   step;
        int   nx;
        int   ny;
        step    = int'(code) << (RADIX - 3);
        nx      = single ? 0 : int'($urandom_range(0, 6));
        ny      = single ? 0 : int'($urandom_range(0, 4));
        b.min_x = coord_t'((int'($urandom_range(0, 127)) - 64) * step);
        b.min_y = coord_t'((int'($urandom_range(0, 127)) - 64) * step);
        b.max_x = coord_t'(int'(b.min_x) + nx * step);
        b.max_y = coord_t'(int'(b.min_y) + ny * step);
        item_code.push_back(code);
        item_chain.push_back(chain);
        item_box.push_back(b);
        item_tri.push_back(rand_tri());
        item_color.push_back(rand_color());
        item_len.push_back(walk_length(b, step));
    endtask

    task automatic present_item(input int i);
        tri_in    <= item_tri[i];
        color_in  <= item_color[i];
        box_in    <= item_box[i];
        subsample <= item_code[i];
        valid_in  <= 1'b1;
    endtask

    // Upstream noise under halt, MSAA code left alone
    task automatic scramble_inputs();
        tri_in   <= rand_tri();
        color_in <= rand_color();
        box_in   <= {$urandom, $urandom, $urandom};
        valid_in <= 1'b0;
    endtask

    initial begin
        int n;
        int gap;
        int total;
        int err_before;
        bit sent_next;
        bit ok;
        void'($urandom(32'h4841));
        // One walk per code first, then chained runs
        add_test(4'b1000, 1'b0, 1'b0);
        add_test(4'b0100, 1'b0, 1'b0);
        add_test(4'b0010, 1'b0, 1'b0);
        add_test(4'b0001, 1'b0, 1'b0);
        add_test(4'b1000, 1'b1, 1'b0);
        add_test(4'b1000, 1'b0, 1'b0);
        add_test(4'b0100, 1'b1, 1'b0);
        add_test(4'b0100, 1'b1, 1'b1);
        add_test(4'b0100, 1'b0, 1'b0);
        add_test(4'b0001, 1'b1, 1'b0);
        add_test(4'b0001, 1'b0, 1'b0);
        add_test(4'b0010, 1'b0, 1'b1);
        total = 0;
        foreach (item_len[k]) begin
            total += item_len[k];
        end
        cycle_limit = 2 * total + 100;

        rst       = 1'b1;
        valid_in  = 1'b0;
        tri_in    = '0;
        color_in  = '0;
        box_in    = '0;
        subsample = 4'b1000;
        repeat (4) @(posedge clk);
        rst <= 1'b0;

        for (int i = 0; i < item_code.size(); i++) begin
            err_before = u_dut.u_chk.err_count;
            ok = 1'b1;
            if (i == 0 || !item_chain[i - 1]) begin
                @(posedge clk);
                present_item(i);
            end
            // Accept shows up as halt_l going low
            gap = 0;
            do begin
                @(negedge clk);
                gap++;
            end while (halt_l);
            if (i > 0 && item_chain[i - 1]) begin
                assert (gap == 1) else begin
                    $display("Fail %0t: %0d idle cycles before chained test %0d",
                             $time, gap, i);
                    ok = 1'b0;
                end
            end
            // Count samples until halt is released
            n = 0;
            sent_next = 1'b0;
            while (!halt_l) begin
                if (sample_valid) begin
                    n++;
                end
                @(posedge clk);
                if (item_chain[i] && !sent_next) begin
                    // Next item sits under halt and goes in on the bubble
                    present_item(i + 1);
                    sent_next = 1'b1;
                end else if (!item_chain[i]) begin
                    scramble_inputs();
                end
                @(negedge clk);
            end
            assert (n == item_len[i]) else begin
                $display("Fail %0t: test %0d gave %0d samples, expected %0d",
                         $time, i, n, item_len[i]);
                ok = 1'b0;
            end
            ok = ok && (u_dut.u_chk.err_count == err_before);
            if (ok) begin
                pass_count++;
            end else begin
                fail_count++;
            end
            $display("Test %0d code %b: %0d of %0d samples, %s",
                     i, item_code[i], n, item_len[i], ok ? "ok" : "error");
        end

        repeat (2) @(posedge clk);
        $display("%0d tests passed, %0d tests failed, %0d assertion errors",
                 pass_count, fail_count, u_dut.u_chk.err_count);
        if (fail_count == 0 && u_dut.u_chk.err_count == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

    // Watchdog, limit set once the walk lengths are known
    initial begin
        wait (cycle_limit > 0);
        while (cycles < cycle_limit) begin
            @(posedge clk);
            cycles++;
        end
        $display("Timeout: run still going after %0d cycles", cycles);
        $display("STATUS: FAIL");
        $finish;
    end

endmodule
